// File: dv/bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bus_checker #(
    parameter int BIT_CLKS = 8
) (
    input wire logic        clk50MHz,
    input wire logic        rst_n,
    input wire logic        cmd_valid,
    input wire logic        cmd_write,
    input wire logic [2:0]  cmd_dev,
    input wire logic [2:0]  cmd_addr,
    input wire logic [31:0] cmd_wdata,
    input wire logic        busy,
    input wire logic        rsp_valid,
    input wire logic [31:0] rsp_data,
    input wire logic        tx,
    input wire logic        pwm_out
);
    int          errors = 0;
    logic [31:0] ram_model [8];
    logic [7:0]  audio_model = 8'h00;
    logic [2:0]  rx_addr = 3'd0;
    logic [32:0] model_q[$];  // bit 32 marks a modeled value
    logic [31:0] table_q[$];  // expected values from the stimulus table
    logic [7:0]  tx_q[$];

    initial begin
        for (int i = 0; i < 8; i++)
            ram_model[i] = '0;
    end

    task automatic expect_read(input logic [31:0] value);
        table_q.push_back(value);
    endtask

    task automatic note_rx(input logic [7:0] value);
        ram_model[rx_addr] = {24'h0, value}; // zero-extended byte
        rx_addr = rx_addr + 3'd1;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // outputs right after reset
    task automatic check_idle();
        compare_bit("busy", busy, 1'b0);
        compare_bit("rsp_valid", rsp_valid, 1'b0);
        compare_bit("tx", tx, 1'b1); // line idles high
        compare_bit("pwm_out", pwm_out, 1'b0);
    endtask

    task automatic count_pwm(input logic [7:0] sample);
        int high;
        high = 0;
        repeat (256) begin
            @(posedge clk50MHz);
            if (pwm_out)
                high++;
        end
        if (high != sample) begin
            errors++;
            $display("FAIL pwm_out high cycles: got %h expected %h", high, sample);
        end
    endtask

    function automatic int tx_pending();
        return tx_q.size();
    endfunction

    task automatic final_checks();
        if (table_q.size() != 0 || model_q.size() != 0) begin
            errors++;
            $display("some host reads never returned a response");
        end
        if (tx_q.size() != 0) begin
            errors++;
            $display("some UART writes never produced a frame on tx");
        end
    endtask

    // command monitor and response compare
    always @(posedge clk50MHz) begin
        logic [32:0] m;
        logic [31:0] t;
        if (rst_n) begin
            if (cmd_valid && !busy) begin
                if (cmd_write) begin
                    case (cmd_dev)
                        3'd0: ram_model[cmd_addr] = cmd_wdata;
                        3'd4: audio_model = cmd_wdata[7:0];
                        3'd6: tx_q.push_back(cmd_wdata[7:0]);
                        default: ;
                    endcase
                end else begin
                    case (cmd_dev)
                        3'd0: model_q.push_back({1'b1, ram_model[cmd_addr]});
                        3'd4: model_q.push_back({1'b1, 24'h0, audio_model});
                        default: model_q.push_back(33'h0); // status not modeled
                    endcase
                end
            end
            if (rsp_valid) begin
                if (table_q.size() == 0 || model_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no read outstanding");
                end else begin
                    t = table_q.pop_front();
                    m = model_q.pop_front();
                    if (rsp_data !== t) begin
                        errors++;
                        $display("FAIL rsp_data: got %h expected %h", rsp_data, t);
                    end
                    if (m[32] && rsp_data !== m[31:0]) begin
                        errors++;
                        $display("FAIL rsp_data vs model: got %h expected %h",
                                 rsp_data, m[31:0]);
                    end
                end
            end
        end
    end

    // tx frame decoder
    always begin
        logic [7:0] b;
        logic [7:0] e;
        @(posedge clk50MHz);
        if (rst_n && tx === 1'b0) begin
            repeat (BIT_CLKS / 2) @(posedge clk50MHz); // middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(posedge clk50MHz);
                b[i] = tx;
            end
            repeat (BIT_CLKS) @(posedge clk50MHz);
            if (tx !== 1'b1) begin
                errors++;
                $display("tx frame had a bad stop bit");
            end
            if (tx_q.size() == 0) begin
                errors++;
                $display("tx sent a frame that nobody wrote");
            end else begin
                e = tx_q.pop_front();
                if (b !== e) begin
                    errors++;
                    $display("FAIL tx byte: got %h expected %h", b, e);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/bus_system_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bus_system_properties (
    input wire logic       clk50MHz,
    input wire logic       rst_n,
    input wire logic       host_req,
    input wire logic       uart_req,
    input wire logic       host_ack,
    input wire logic       uart_ack,
    input wire logic [7:0] host_ctrl,
    input wire logic [7:0] uart_ctrl,
    input wire logic [7:0] bus_ctrl
);
    import bus_pkg::*;

    a_one_ack: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        !(host_ack && uart_ack))
        else $error("both masters granted in one cycle");

    // read word on the bus, then the slave reply cycle
    a_no_ack_in_read: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        (bus_ctrl[7:6] == op_read) |-> !(host_ack || uart_ack) ##1 !(host_ack || uart_ack))
        else $error("grant while a read is pending");

    a_host_ack_req: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        host_ack |-> host_req ##1 (bus_ctrl == $past(host_ctrl)))
        else $error("host ack without request or host word missing from the bus");

    a_uart_ack_req: assert property (@(posedge clk50MHz) disable iff (!rst_n)
        uart_ack |-> uart_req ##1 (bus_ctrl == $past(uart_ctrl)))
        else $error("uart ack without request or uart word missing from the bus");

endmodule

bind bus_arbiter bus_system_properties i_props (
    .clk50MHz(clk50MHz), .rst_n(rst_n),
    .host_req(host_req), .uart_req(uart_req),
    .host_ack(host_ack), .uart_ack(uart_ack),
    .host_ctrl(host_ctrl), .uart_ctrl(uart_ctrl),
    .bus_ctrl(bus_ctrl)
);

`default_nettype wire

// File: dv/tb_bus_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_system;
    localparam int BIT = 8;
    localparam int ROWS = 40;

    // row actions
    localparam int ACT_CMD = 0;
    localparam int ACT_RX_OK = 1;
    localparam int ACT_RX_BAD = 2;
    localparam int ACT_PWM = 3;
    localparam int ACT_RX_OVERLAP = 4;

    logic        clk50MHz, rst_n;
    logic        cmd_valid = 1'b0, cmd_write = 1'b0;
    logic [2:0]  cmd_dev = '0, cmd_addr = '0;
    logic [31:0] cmd_wdata = '0;
    logic        rx = 1'b1;
    wire logic        busy, rsp_valid, tx, pwm_out;
    wire logic [31:0] rsp_data;

    int          t_act [ROWS];
    logic        t_wr [ROWS];
    logic [2:0]  t_dev [ROWS];
    logic [2:0]  t_addr [ROWS];
    logic [31:0] t_wdata [ROWS];
    logic [31:0] t_exp [ROWS];
    int          nrows = 0;
    logic [31:0] rnd_state = 32'h1440_0f3c;
    logic [31:0] ram_vals [8];

    tb_clock i_clock (.clk50MHz(clk50MHz), .rst_n(rst_n));

    bus_system #(.UART_BIT_CLKS(BIT)) i_dut (
        .clk50MHz(clk50MHz), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_dev(cmd_dev),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .busy(busy), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .rx(rx), .tx(tx), .pwm_out(pwm_out)
    );

    bus_checker #(.BIT_CLKS(BIT)) i_checker (
        .clk50MHz(clk50MHz), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_dev(cmd_dev),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .busy(busy),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .tx(tx), .pwm_out(pwm_out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input int act, input logic wr, input logic [2:0] dev,
                           input logic [2:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp);
        t_act[nrows] = act;
        t_wr[nrows] = wr;
        t_dev[nrows] = dev;
        t_addr[nrows] = addr;
        t_wdata[nrows] = wdata;
        t_exp[nrows] = exp;
        nrows++;
    endtask

    task automatic build_table();
        logic [7:0] s;
        for (int i = 0; i < 8; i++)
            add_row(ACT_CMD, 0, 3'd0, 3'(i), '0, '0); // cleared at reset
        for (int i = 0; i < 8; i++) begin
            rnd_state = xorshift32(rnd_state);
            ram_vals[i] = rnd_state;
            add_row(ACT_CMD, 1, 3'd0, 3'(i), ram_vals[i], '0);
        end
        for (int i = 0; i < 8; i++)
            add_row(ACT_CMD, 0, 3'd0, 3'(i), '0, ram_vals[i]);
        rnd_state = xorshift32(rnd_state);
        s = rnd_state[7:0];
        add_row(ACT_CMD, 1, 3'd4, 3'd0, {24'h0, s}, '0);
        add_row(ACT_CMD, 0, 3'd4, 3'd0, '0, {24'h0, s});
        add_row(ACT_PWM, 0, 3'd4, 3'd0, '0, {24'h0, s});
        add_row(ACT_CMD, 1, 3'd6, 3'd0, 32'h0000_12a5, '0);
        add_row(ACT_CMD, 0, 3'd6, 3'd0, '0, 32'h1); // tx still busy
        add_row(ACT_RX_OK, 0, 3'd0, 3'd0, 32'h11, '0);
        add_row(ACT_RX_OK, 0, 3'd0, 3'd0, 32'h22, '0);
        add_row(ACT_RX_OK, 0, 3'd0, 3'd0, 32'h33, '0);
        add_row(ACT_RX_BAD, 0, 3'd0, 3'd0, 32'h44, '0);
        add_row(ACT_CMD, 0, 3'd0, 3'd0, '0, 32'h11);
        add_row(ACT_CMD, 0, 3'd0, 3'd1, '0, 32'h22);
        add_row(ACT_CMD, 0, 3'd0, 3'd2, '0, 32'h33);
        add_row(ACT_CMD, 0, 3'd0, 3'd3, '0, ram_vals[3]); // bad frame left it alone
        add_row(ACT_RX_OVERLAP, 0, 3'd0, 3'd7, 32'h55, ram_vals[7]);
        add_row(ACT_CMD, 0, 3'd0, 3'd3, '0, 32'h55);
    endtask

    task automatic wait_not_busy(input string what);
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(negedge clk50MHz);
            n++;
        end
        if (busy)
            i_checker.report_timeout(what);
    endtask

    task automatic run_cmd(input logic wr, input logic [2:0] dev, input logic [2:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp);
        @(negedge clk50MHz);
        wait_not_busy("host port stayed busy before a new command");
        if (!wr)
            i_checker.expect_read(exp);
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_dev = dev;
        cmd_addr = addr;
        cmd_wdata = wdata;
        @(negedge clk50MHz);
        cmd_valid = 1'b0;
        wait_not_busy("host command did not complete");
        @(negedge clk50MHz); // let rsp_valid land
    endtask

    task automatic send_rx(input logic [7:0] b, input logic stop_ok);
        @(negedge clk50MHz);
        rx = 1'b0;
        repeat (BIT) @(negedge clk50MHz);
        for (int i = 0; i < 8; i++) begin
            rx = b[i]; // lsb first
            repeat (BIT) @(negedge clk50MHz);
        end
        rx = stop_ok;
        repeat (BIT) @(negedge clk50MHz);
        rx = 1'b1;
        repeat (2 * BIT) @(negedge clk50MHz);
    endtask

    initial begin
        int n;
        build_table();
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk50MHz);
            n++;
        end
        if (rst_n !== 1'b1)
            i_checker.report_timeout("reset never released");
        i_checker.check_idle();
        for (int r = 0; r < nrows; r++) begin
            case (t_act[r])
                ACT_CMD: run_cmd(t_wr[r], t_dev[r], t_addr[r], t_wdata[r], t_exp[r]);
                ACT_RX_OK: begin
                    send_rx(t_wdata[r][7:0], 1'b1);
                    i_checker.note_rx(t_wdata[r][7:0]);
                end
                ACT_RX_BAD: send_rx(t_wdata[r][7:0], 1'b0);
                ACT_PWM: begin
                    repeat (4) @(negedge clk50MHz);
                    i_checker.count_pwm(t_exp[r][7:0]);
                end
                ACT_RX_OVERLAP: begin
                    // second host read requests in the same cycle as the rx byte post
                    fork
                        send_rx(t_wdata[r][7:0], 1'b1);
                        begin
                            repeat (9 * BIT - 1) @(negedge clk50MHz);
                            repeat (4)
                                run_cmd(1'b0, t_dev[r], t_addr[r], '0, t_exp[r]);
                        end
                    join
                    i_checker.note_rx(t_wdata[r][7:0]);
                end
                default: ;
            endcase
        end
        n = 0;
        while (i_checker.tx_pending() != 0 && n < 300) begin
            @(negedge clk50MHz);
            n++;
        end
        if (i_checker.tx_pending() != 0)
            i_checker.report_timeout("tx frame never finished");
        repeat (4) @(negedge clk50MHz);
        i_checker.final_checks();
        $display("errors: %0d", i_checker.errors);
        if (i_checker.errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk50MHz,
    output logic rst_n
);
    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz; // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk50MHz);
        @(negedge clk50MHz);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: include/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// shared bus geometry

// bus data word width
`define BUS_DATA_W 32

// control word width
`define BUS_CTRL_W 8

// scratch RAM depth in words
`define RAM_WORDS 8

// 50 MHz / 115200 baud
`define UART_BIT_CLKS 434

// audio resolution
`define PWM_BITS 8

`endif

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module bus_arbiter (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic                     host_req,
    input  logic                     uart_req,
    input  logic [`BUS_CTRL_W-1:0]   host_ctrl,
    input  logic [`BUS_CTRL_W-1:0]   uart_ctrl,
    input  logic [`BUS_DATA_W-1:0]   host_data,
    input  logic [`BUS_DATA_W-1:0]   uart_data,
    input  logic [`BUS_CTRL_W-1:0]   reply_ctrl,
    input  logic [`BUS_DATA_W-1:0]   reply_data,
    output logic                     host_ack,
    output logic                     uart_ack,
    output logic [`BUS_CTRL_W-1:0]   bus_ctrl,
    output logic [`BUS_DATA_W-1:0]   bus_data
);
    import bus_pkg::*;

    arb_state_e               state;
    logic                     wait_second; // slave reply is on reply_ctrl now
    dev_id_e                  req_id;      // owner of the outstanding read
    logic                     grant;
    logic [`BUS_CTRL_W-1:0]   win_ctrl;
    logic [`BUS_DATA_W-1:0]   win_data;
    bus_op_e                  reply_op;

    // uart wins over host
    assign uart_ack = uart_req && (state == arb_idle);
    assign host_ack = host_req && !uart_req && (state == arb_idle);
    assign grant    = uart_ack || host_ack;
    assign win_ctrl = uart_ack ? uart_ctrl : host_ctrl;
    assign win_data = uart_ack ? uart_data : host_data;
    assign reply_op = bus_op_e'(reply_ctrl[7:6]);

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            state       <= arb_idle;
            wait_second <= 1'b0;
            req_id      <= dev_host;
            bus_ctrl    <= '0;
        end else begin
            bus_ctrl <= '0; // one-cycle bus words
            case (state)
                arb_idle: begin
                    if (grant) begin
                        bus_ctrl <= win_ctrl;
                        if (bus_op_e'(win_ctrl[7:6]) == op_read) begin
                            state       <= arb_wait_resp;
                            wait_second <= 1'b0;
                            req_id      <= uart_ack ? dev_uart : dev_host;
                        end
                    end
                end
                arb_wait_resp: begin
                    wait_second <= 1'b1;
                    if (wait_second) begin
                        // always close the read, even if nobody answered
                        bus_ctrl <= {op_resp, req_id, reply_ctrl[2:0]};
                        state    <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (grant)
            bus_data <= win_data;
        else if (state == arb_wait_resp && wait_second)
            bus_data <= (reply_op == op_resp) ? reply_data : '0;
    end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // control bits 7..6
    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_write = 2'd1,
        op_read  = 2'd2,
        op_resp  = 2'd3
    } bus_op_e;

    // control bits 5..3
    typedef enum logic [2:0] {
        dev_ram   = 3'd0,
        dev_audio = 3'd4,
        dev_uart  = 3'd6,
        dev_host  = 3'd7
    } dev_id_e;

    typedef enum logic {
        arb_idle,
        arb_wait_resp
    } arb_state_e;

endpackage

`default_nettype wire

// File: src/bus_system.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module bus_system #(
    parameter int UART_BIT_CLKS = `UART_BIT_CLKS
) (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  logic                     cmd_write,
    input  logic [2:0]               cmd_dev,
    input  logic [2:0]               cmd_addr,
    input  logic [`BUS_DATA_W-1:0]   cmd_wdata,
    output logic                     busy,
    output logic                     rsp_valid,
    output logic [`BUS_DATA_W-1:0]   rsp_data,
    input  logic                     rx,
    output logic                     tx,
    output logic                     pwm_out
);
    logic                     host_req, host_ack, uart_req, uart_ack;
    logic [`BUS_CTRL_W-1:0]   host_ctrl, uart_ctrl, ram_ctrl, audio_ctrl;
    logic [`BUS_DATA_W-1:0]   host_data, uart_data, ram_data, audio_data;
    logic [`BUS_CTRL_W-1:0]   bus_ctrl, reply_ctrl;
    logic [`BUS_DATA_W-1:0]   bus_data, reply_data;

    // idle slaves drive zeros
    assign reply_ctrl = ram_ctrl | uart_ctrl | audio_ctrl;
    assign reply_data = ram_data | uart_data | audio_data;

    bus_arbiter i_arbiter (
        .clk50MHz(clk50MHz), .rst_n(rst_n),
        .host_req(host_req), .uart_req(uart_req),
        .host_ctrl(host_ctrl), .uart_ctrl(uart_ctrl),
        .host_data(host_data), .uart_data(uart_data),
        .reply_ctrl(reply_ctrl), .reply_data(reply_data),
        .host_ack(host_ack), .uart_ack(uart_ack),
        .bus_ctrl(bus_ctrl), .bus_data(bus_data)
    );

    host_port i_host (
        .clk50MHz(clk50MHz), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_write(cmd_write), .cmd_dev(cmd_dev),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .ack(host_ack),
        .bus_ctrl(bus_ctrl), .bus_data(bus_data), .busy(busy), .req(host_req),
        .ctrl_out(host_ctrl), .data_out(host_data),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

    scratch_ram i_ram (
        .clk50MHz(clk50MHz), .rst_n(rst_n), .bus_ctrl(bus_ctrl), .bus_data(bus_data),
        .ctrl_out(ram_ctrl), .data_out(ram_data)
    );

    uart_device #(.BIT_CLKS(UART_BIT_CLKS)) i_uart (
        .clk50MHz(clk50MHz), .rst_n(rst_n), .bus_ctrl(bus_ctrl), .bus_data(bus_data),
        .ack(uart_ack), .rx(rx), .tx(tx), .req(uart_req),
        .ctrl_out(uart_ctrl), .data_out(uart_data)
    );

    pwm_audio i_audio (
        .clk50MHz(clk50MHz), .rst_n(rst_n), .bus_ctrl(bus_ctrl), .bus_data(bus_data),
        .ctrl_out(audio_ctrl), .data_out(audio_data), .pwm_out(pwm_out)
    );

endmodule

`default_nettype wire

// File: src/host_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module host_port (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  logic                     cmd_write,
    input  logic [2:0]               cmd_dev,
    input  logic [2:0]               cmd_addr,
    input  logic [`BUS_DATA_W-1:0]   cmd_wdata,
    input  logic                     ack,
    input  logic [`BUS_CTRL_W-1:0]   bus_ctrl,
    input  logic [`BUS_DATA_W-1:0]   bus_data,
    output logic                     busy,
    output logic                     req,
    output logic [`BUS_CTRL_W-1:0]   ctrl_out,
    output logic [`BUS_DATA_W-1:0]   data_out,
    output logic                     rsp_valid,
    output logic [`BUS_DATA_W-1:0]   rsp_data
);
    import bus_pkg::*;

    logic    pending;  // command waiting for a grant
    logic    wait_rsp; // read granted, reply not yet seen
    logic    is_read;
    logic    accept;
    logic    rsp_hit;
    bus_op_e bus_op;
    dev_id_e bus_dev;

    assign bus_op  = bus_op_e'(bus_ctrl[7:6]);
    assign bus_dev = dev_id_e'(bus_ctrl[5:3]);
    assign busy    = pending || wait_rsp;
    assign req     = pending; // re-strobe every cycle until ack
    assign accept  = cmd_valid && !busy;
    assign rsp_hit = wait_rsp && (bus_op == op_resp) && (bus_dev == dev_host);

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            wait_rsp  <= 1'b0;
            is_read   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (accept) begin
                pending <= 1'b1;
                is_read <= !cmd_write;
            end else if (pending && ack) begin
                pending  <= 1'b0;
                wait_rsp <= is_read;
            end
            if (rsp_hit) begin
                wait_rsp  <= 1'b0;
                rsp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (accept) begin
            ctrl_out <= {(cmd_write ? op_write : op_read), cmd_dev, cmd_addr};
            // a read carries our id so the slave can tag its reply
            data_out <= cmd_write ? cmd_wdata : `BUS_DATA_W'(dev_host);
        end
        if (rsp_hit)
            rsp_data <= bus_data;
    end

endmodule

`default_nettype wire

// File: src/pwm_audio.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module pwm_audio (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic [`BUS_CTRL_W-1:0]   bus_ctrl,
    input  logic [`BUS_DATA_W-1:0]   bus_data,
    output logic [`BUS_CTRL_W-1:0]   ctrl_out,
    output logic [`BUS_DATA_W-1:0]   data_out,
    output logic                     pwm_out
);
    import bus_pkg::*;

    logic [`PWM_BITS-1:0] sample;
    logic [`PWM_BITS-1:0] pwm_cnt; // free-running
    bus_op_e              bus_op;
    dev_id_e              bus_dev;

    assign bus_op  = bus_op_e'(bus_ctrl[7:6]);
    assign bus_dev = dev_id_e'(bus_ctrl[5:3]);

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            sample <= '0;
            pwm_cnt <= '0;
            pwm_out <= 1'b0;
            ctrl_out <= '0;
            data_out <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            pwm_out <= (pwm_cnt < sample); // sample high cycles per period
            ctrl_out <= '0;
            data_out <= '0;
            if (bus_dev == dev_audio && bus_op == op_write)
                sample <= bus_data[`PWM_BITS-1:0];
            if (bus_dev == dev_audio && bus_op == op_read) begin
                ctrl_out <= {op_resp, dev_audio, bus_data[2:0]};
                data_out <= `BUS_DATA_W'(sample);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module scratch_ram (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic [`BUS_CTRL_W-1:0]   bus_ctrl,
    input  logic [`BUS_DATA_W-1:0]   bus_data,
    output logic [`BUS_CTRL_W-1:0]   ctrl_out,
    output logic [`BUS_DATA_W-1:0]   data_out
);
    import bus_pkg::*;

    logic [`BUS_DATA_W-1:0] mem [`RAM_WORDS];
    bus_op_e                bus_op;
    dev_id_e                bus_dev;
    logic [2:0]             addr;
    logic                   hit;

    assign bus_op  = bus_op_e'(bus_ctrl[7:6]);
    assign bus_dev = dev_id_e'(bus_ctrl[5:3]);
    assign addr    = bus_ctrl[2:0];
    assign hit     = (bus_dev == dev_ram);

    // storage, cleared so unwritten words read as zero
    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            for (int i = 0; i < `RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (hit && bus_op == op_write) begin
            mem[addr] <= bus_data;
        end
    end

    // read reply, one cycle after the read word
    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            ctrl_out <= '0;
            data_out <= '0;
        end else if (hit && bus_op == op_read) begin
            ctrl_out <= {op_resp, dev_ram, bus_data[2:0]}; // requester id in addr field
            data_out <= mem[addr];
        end else begin
            ctrl_out <= '0; // replies are ORed, so stay quiet
            data_out <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/uart_device.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_settings.svh"

module uart_device #(
    parameter int BIT_CLKS = `UART_BIT_CLKS
) (
    input  logic                     clk50MHz,
    input  logic                     rst_n,
    input  logic [`BUS_CTRL_W-1:0]   bus_ctrl,
    input  logic [`BUS_DATA_W-1:0]   bus_data,
    input  logic                     ack,
    input  logic                     rx,
    output logic                     tx,
    output logic                     req,
    output logic [`BUS_CTRL_W-1:0]   ctrl_out,
    output logic [`BUS_DATA_W-1:0]   data_out
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(BIT_CLKS + 1);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

    bus_op_e    bus_op;
    dev_id_e    bus_dev;
    logic [9:0] tx_shift;   // stop, data, start
    logic [3:0] tx_bits;
    logic [CNT_W-1:0] tx_cnt;
    logic       tx_busy;
    logic       rsp_valid;
    logic [2:0] rsp_tag;
    logic       rsp_busy;
    logic       reply_slot; // slaves answer in this cycle
    logic [1:0] rx_sync;
    rx_state_e  rx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0] rx_bits;
    logic [7:0] rx_byte;
    logic       post_pending;
    logic [7:0] post_byte;
    logic [2:0] post_addr;

    assign bus_op  = bus_op_e'(bus_ctrl[7:6]);
    assign bus_dev = dev_id_e'(bus_ctrl[5:3]);
    assign tx      = tx_shift[0];
    // hold off while slave replies are being ORed
    assign req      = post_pending && !reply_slot;
    assign ctrl_out = req ? {op_write, dev_ram, post_addr} :
                      rsp_valid ? {op_resp, dev_uart, rsp_tag} : '0;
    assign data_out = req ? {{(`BUS_DATA_W-8){1'b0}}, post_byte} :
                      rsp_valid ? `BUS_DATA_W'(rsp_busy) : '0;

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            tx_shift <= '1;
            tx_busy <= 1'b0;
            tx_bits <= '0;
            tx_cnt <= '0;
        end else if (!tx_busy) begin
            if (bus_op == op_write && bus_dev == dev_uart) begin
                tx_shift <= {1'b1, bus_data[7:0], 1'b0};
                tx_busy <= 1'b1;
                tx_bits <= '0;
                tx_cnt <= '0;
            end
        end else if (tx_cnt == CNT_W'(BIT_CLKS - 1)) begin
            tx_cnt <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bits == 4'd9)
                tx_busy <= 1'b0;
            else
                tx_bits <= tx_bits + 4'd1;
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_tag <= '0;
            rsp_busy <= 1'b0;
            reply_slot <= 1'b0;
        end else begin
            reply_slot <= (bus_op == op_read);
            rsp_valid <= (bus_op == op_read) && (bus_dev == dev_uart);
            rsp_tag <= bus_data[2:0];
            rsp_busy <= tx_busy; // status bit 0
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_state <= rx_idle;
            rx_cnt <= '0;
            rx_bits <= '0;
            rx_byte <= '0;
            post_pending <= 1'b0;
            post_byte <= '0;
            post_addr <= '0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            if (post_pending && ack) begin
                post_pending <= 1'b0;
                post_addr <= (post_addr == 3'(`RAM_WORDS - 1)) ? 3'd0 : post_addr + 3'd1;
            end
            case (rx_state)
                rx_idle: begin
                    rx_cnt <= '0;
                    if (!rx_sync[1])
                        rx_state <= rx_start;
                end
                rx_start: begin
                    if (rx_cnt == CNT_W'(BIT_CLKS / 2 - 1)) begin // middle of start bit
                        rx_cnt <= '0;
                        rx_bits <= '0;
                        rx_state <= rx_sync[1] ? rx_idle : rx_data;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (rx_cnt == CNT_W'(BIT_CLKS - 1)) begin
                        rx_cnt <= '0;
                        rx_byte <= {rx_sync[1], rx_byte[7:1]}; // lsb first
                        if (rx_bits == 3'd7)
                            rx_state <= rx_stop;
                        else
                            rx_bits <= rx_bits + 3'd1;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (rx_cnt == CNT_W'(BIT_CLKS - 1)) begin
                        rx_state <= rx_idle;
                        if (rx_sync[1]) begin // bad stop bit drops the byte
                            post_pending <= 1'b1;
                            post_byte <= rx_byte;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= rx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
src/bus_pkg.sv
src/bus_arbiter.sv
src/host_port.sv
src/scratch_ram.sv
src/uart_device.sv
src/pwm_audio.sv
src/bus_system.sv
dv/tb_clock.sv
dv/bus_checker.sv
dv/bus_system_properties.sv
dv/tb_bus_system.sv
